//--- filelist.f
rtl/bt_bridge_pkg.sv
rtl/stream_fifo_bank.sv
rtl/channel_arbiter.sv
rtl/packet_sequencer.sv
rtl/uart_tx.sv
rtl/bt_stream_bridge.sv
sim/bt_stream_bridge_asserts.sv
sim/bt_stream_bridge_tb.sv

//--- rtl/bt_bridge_pkg.sv
// Shared widths, sample and packet types, stream word struct and sequencer states
package bt_bridge_pkg;

	// Sample and channel sizes
	localparam int SAMPLE_W = 110;
	localparam int STREAM_ID_W = 3;
	localparam int N_STREAMS = 2 ** STREAM_ID_W;

	// A packet is channel byte, padded sample, channel byte
	localparam int PACKET_BYTES = 16;

	typedef logic [SAMPLE_W-1:0] sample_t;
	typedef logic [7:0] byte_t;
	typedef logic [PACKET_BYTES*8-1:0] packet_t;
	typedef logic [3:0] byte_index_t;
	typedef logic [STREAM_ID_W-1:0] stream_id_t;

	// UART and spacing counts, all in clock cycles
	typedef logic [9:0] bit_period_t;
	typedef logic [9:0] gap_t;
	typedef logic [15:0] packet_gap_t;

	// Granted channel together with the head of its FIFO
	typedef struct packed {
		stream_id_t id;
		sample_t sample;
	} stream_word_t;

	typedef enum logic [2:0] {
		SEQ_IDLE,
		SEQ_LOAD,
		SEQ_SEND,
		SEQ_WAIT_DONE,
		SEQ_BYTE_GAP,
		SEQ_PACKET_GAP
	} seq_state_t;

endpackage

//--- rtl/bt_stream_bridge.sv
// Sensor to Bluetooth UART bridge top level joining FIFOs, arbiter, sequencer and UART
module bt_stream_bridge #(
	parameter int FIFO_DEPTH = 4,
	parameter bt_bridge_pkg::packet_gap_t PACKET_GAP = 16'd6000
) (
	input  logic clock,
	input  logic reset,
	input  bt_bridge_pkg::sample_t [bt_bridge_pkg::N_STREAMS-1:0] sample_i,
	input  logic [bt_bridge_pkg::N_STREAMS-1:0] sample_valid_i,
	input  logic [bt_bridge_pkg::N_STREAMS-1:0] stream_enable_i,
	input  logic send_enable_i,
	input  bt_bridge_pkg::bit_period_t bit_period_i,
	input  bt_bridge_pkg::gap_t byte_gap_i,
	output logic txd_o,
	output logic busy_o
);
	import bt_bridge_pkg::*;

	logic [N_STREAMS-1:0] empty;
	stream_word_t head;
	logic grant_valid;
	stream_id_t grant_id;
	logic pop;
	logic tx_start;
	byte_t tx_byte;
	logic tx_done;

	stream_fifo_bank #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) fifo_bank0 (
		.clock(clock),
		.reset(reset),
		.sample_i(sample_i),
		.sample_valid_i(sample_valid_i),
		.pop_i(pop),
		.pop_id_i(grant_id),
		.empty_o(empty),
		.head_o(head)
	);

	channel_arbiter arbiter0 (
		.clock(clock),
		.reset(reset),
		.empty_i(empty),
		.stream_enable_i(stream_enable_i),
		.send_enable_i(send_enable_i),
		.pop_i(pop),
		.grant_valid_o(grant_valid),
		.grant_id_o(grant_id)
	);

	packet_sequencer #(
		.PACKET_GAP(PACKET_GAP)
	) sequencer0 (
		.clock(clock),
		.reset(reset),
		.grant_valid_i(grant_valid),
		.head_i(head),
		.byte_gap_i(byte_gap_i),
		.tx_done_i(tx_done),
		.pop_o(pop),
		.tx_start_o(tx_start),
		.tx_byte_o(tx_byte),
		.busy_o(busy_o)
	);

	uart_tx uart0 (
		.clock(clock),
		.reset(reset),
		.start_i(tx_start),
		.data_i(tx_byte),
		.bit_period_i(bit_period_i),
		.txd_o(txd_o),
		.done_o(tx_done)
	);

endmodule

//--- rtl/channel_arbiter.sv
// Round-robin grant over the non-empty, enabled sensor channels
module channel_arbiter (
	input  logic clock,
	input  logic reset,
	input  logic [bt_bridge_pkg::N_STREAMS-1:0] empty_i,
	input  logic [bt_bridge_pkg::N_STREAMS-1:0] stream_enable_i,
	input  logic send_enable_i,
	input  logic pop_i,
	output logic grant_valid_o,
	output bt_bridge_pkg::stream_id_t grant_id_o
);
	import bt_bridge_pkg::*;

	stream_id_t last_q;
	stream_id_t pick;
	logic [N_STREAMS-1:0] ready;
	logic found;

	assign ready = ~empty_i & stream_enable_i;

	// Search starts one past the channel served last and wraps around
	always_comb
	begin
		stream_id_t cand;
		pick = '0;
		found = 1'b0;
		for (int i = 1; i <= N_STREAMS; i++)
		begin
			cand = last_q + stream_id_t'(i);
			if (!found && ready[cand])
			begin
				pick = cand;
				found = 1'b1;
			end
		end
	end

	assign grant_valid_o = send_enable_i && found;
	assign grant_id_o = pick;

	// Last channel is the reset value so channel 0 is searched first
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			last_q <= stream_id_t'(N_STREAMS - 1);
		else if (pop_i)
			last_q <= grant_id_o;
	end

endmodule

//--- rtl/packet_sequencer.sv
// Packet framing FSM with byte indexing and byte and packet spacing
module packet_sequencer #(
	parameter bt_bridge_pkg::packet_gap_t PACKET_GAP = 16'd6000
) (
	input  logic clock,
	input  logic reset,
	input  logic grant_valid_i,
	input  bt_bridge_pkg::stream_word_t head_i,
	input  bt_bridge_pkg::gap_t byte_gap_i,
	input  logic tx_done_i,
	output logic pop_o,
	output logic tx_start_o,
	output bt_bridge_pkg::byte_t tx_byte_o,
	output logic busy_o
);
	import bt_bridge_pkg::*;

	// Zero bits between the sample and the leading channel byte
	localparam int PAD_W = (PACKET_BYTES - 2) * 8 - SAMPLE_W;
	localparam byte_index_t LAST_BYTE = byte_index_t'(PACKET_BYTES - 1);

	seq_state_t state_q;
	packet_t packet_q;
	byte_index_t byte_idx_q;
	packet_gap_t gap_cnt_q;
	logic byte_gap_done;
	logic packet_gap_done;

	// Grant is checked again here, the arbiter and FIFO act on this pulse
	assign pop_o = (state_q == SEQ_LOAD) && grant_valid_i;
	assign tx_start_o = (state_q == SEQ_SEND);
	assign busy_o = (state_q != SEQ_IDLE);

	// Byte 0 sits in the top bits of the packet
	assign tx_byte_o = packet_q[(PACKET_BYTES - 1 - int'(byte_idx_q)) * 8 +: 8];

	// One counter shared by both gaps, starting at 1 on entry
	assign byte_gap_done = (gap_cnt_q >= packet_gap_t'(byte_gap_i));
	assign packet_gap_done = (gap_cnt_q >= PACKET_GAP);

	always_ff @(posedge clock)
	begin
		if (pop_o)
			packet_q <= {byte_t'(head_i.id), {PAD_W{1'b0}}, head_i.sample, byte_t'(head_i.id)};
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state_q <= SEQ_IDLE;
			byte_idx_q <= '0;
			gap_cnt_q <= '0;
		end
		else
		begin
			case (state_q)
				SEQ_IDLE:
				begin
					if (grant_valid_i)
						state_q <= SEQ_LOAD;
				end

				SEQ_LOAD:
				begin
					byte_idx_q <= '0;
					// Grant may have gone away since the idle cycle
					state_q <= grant_valid_i ? SEQ_SEND : SEQ_IDLE;
				end

				SEQ_SEND:
				begin
					state_q <= SEQ_WAIT_DONE;
				end

				SEQ_WAIT_DONE:
				begin
					if (tx_done_i)
					begin
						gap_cnt_q <= packet_gap_t'(1);
						if (byte_idx_q == LAST_BYTE)
						begin
							state_q <= SEQ_PACKET_GAP;
						end
						else
						begin
							byte_idx_q <= byte_idx_q + 1'b1;
							state_q <= SEQ_BYTE_GAP;
						end
					end
				end

				SEQ_BYTE_GAP:
				begin
					if (byte_gap_done)
						state_q <= SEQ_SEND;
					else
						gap_cnt_q <= gap_cnt_q + 1'b1;
				end

				SEQ_PACKET_GAP:
				begin
					if (packet_gap_done)
						state_q <= SEQ_IDLE;
					else
						gap_cnt_q <= gap_cnt_q + 1'b1;
				end

				default:
				begin
					state_q <= SEQ_IDLE;
				end
			endcase
		end
	end

endmodule

//--- rtl/stream_fifo_bank.sv
// Per-channel first-word-fall-through sample FIFOs with drop on full
module stream_fifo_bank #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic clock,
	input  logic reset,
	input  bt_bridge_pkg::sample_t [bt_bridge_pkg::N_STREAMS-1:0] sample_i,
	input  logic [bt_bridge_pkg::N_STREAMS-1:0] sample_valid_i,
	input  logic pop_i,
	input  bt_bridge_pkg::stream_id_t pop_id_i,
	output logic [bt_bridge_pkg::N_STREAMS-1:0] empty_o,
	output bt_bridge_pkg::stream_word_t head_o
);
	import bt_bridge_pkg::*;

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(FIFO_DEPTH - 1);

	// Head sample of every channel, selected below by the pop id
	sample_t heads [N_STREAMS];

	for (genvar k = 0; k < N_STREAMS; k++)
	begin : g_chan
		sample_t mem [FIFO_DEPTH];
		logic [PTR_W-1:0] rd_ptr_q;
		logic [PTR_W-1:0] wr_ptr_q;
		logic [CNT_W-1:0] count_q;
		logic push;
		logic pull;

		// New samples are lost while the buffer is full
		assign push = sample_valid_i[k] && (count_q != CNT_W'(FIFO_DEPTH));
		assign pull = pop_i && (pop_id_i == stream_id_t'(k)) && (count_q != '0);

		assign empty_o[k] = (count_q == '0);
		assign heads[k] = mem[rd_ptr_q];

		always_ff @(posedge clock)
		begin
			if (push)
				mem[wr_ptr_q] <= sample_i[k];
		end

		always_ff @(posedge clock or posedge reset)
		begin
			if (reset)
			begin
				rd_ptr_q <= '0;
				wr_ptr_q <= '0;
				count_q <= '0;
			end
			else
			begin
				if (push)
					wr_ptr_q <= (wr_ptr_q == LAST_SLOT) ? '0 : wr_ptr_q + 1'b1;
				if (pull)
					rd_ptr_q <= (rd_ptr_q == LAST_SLOT) ? '0 : rd_ptr_q + 1'b1;
				if (push && !pull)
					count_q <= count_q + 1'b1;
				else if (pull && !push)
					count_q <= count_q - 1'b1;
			end
		end
	end

	assign head_o.id = pop_id_i;
	assign head_o.sample = heads[pop_id_i];

endmodule

//--- rtl/uart_tx.sv
// 8N1 UART transmitter with a programmable bit period
module uart_tx (
	input  logic clock,
	input  logic reset,
	input  logic start_i,
	input  bt_bridge_pkg::byte_t data_i,
	input  bt_bridge_pkg::bit_period_t bit_period_i,
	output logic txd_o,
	output logic done_o
);
	import bt_bridge_pkg::*;

	// Start bit, eight data bits, stop bit
	localparam int FRAME_BITS = 10;

	logic [FRAME_BITS-1:0] shift_q;
	logic [3:0] bit_cnt_q;
	bit_period_t period_cnt_q;
	logic active_q;
	logic bit_end;
	logic last_bit;

	assign bit_end = (period_cnt_q == bit_period_i - bit_period_t'(1));
	assign last_bit = (bit_cnt_q == 4'(FRAME_BITS - 1));

	// Line idles high outside a frame
	assign txd_o = active_q ? shift_q[0] : 1'b1;
	assign done_o = active_q && last_bit && bit_end;

	always_ff @(posedge clock)
	begin
		if (start_i && !active_q)
			shift_q <= {1'b1, data_i, 1'b0};
		else if (active_q && bit_end)
			shift_q <= {1'b1, shift_q[FRAME_BITS-1:1]};
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			active_q <= 1'b0;
			bit_cnt_q <= '0;
			period_cnt_q <= '0;
		end
		else if (!active_q)
		begin
			if (start_i)
			begin
				active_q <= 1'b1;
				bit_cnt_q <= '0;
				period_cnt_q <= '0;
			end
		end
		else if (bit_end)
		begin
			period_cnt_q <= '0;
			bit_cnt_q <= bit_cnt_q + 1'b1;
			if (last_bit)
				active_q <= 1'b0;
		end
		else
		begin
			period_cnt_q <= period_cnt_q + 1'b1;
		end
	end

endmodule

//--- sim/bt_stream_bridge_asserts.sv
// Concurrent checks on the serial line, reset state, UART start and pop rules, with bind
module bt_stream_bridge_asserts (
	input  logic clock,
	input  logic reset,
	input  logic txd_i,
	input  logic busy_i,
	input  logic pop_i,
	input  logic grant_valid_i,
	input  bt_bridge_pkg::stream_id_t grant_id_i,
	input  logic [bt_bridge_pkg::N_STREAMS-1:0] empty_i,
	input  logic [bt_bridge_pkg::N_STREAMS-1:0] stream_enable_i,
	input  logic tx_start_i,
	input  logic tx_done_i
);
	int fail_count = 0;
	logic in_frame_q;

	// Frame runs from a UART start to its done pulse
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			in_frame_q <= 1'b0;
		else if (tx_start_i)
			in_frame_q <= 1'b1;
		else if (tx_done_i)
			in_frame_q <= 1'b0;
	end

	idle_line_high: assert property (@(posedge clock) disable iff (reset) !busy_i |-> txd_i)
	else
	begin
		fail_count++;
		$error("Serial line low while the bridge is idle");
	end

	idle_after_reset: assert property (@(posedge clock) $fell(reset) |-> !busy_i)
	else
	begin
		fail_count++;
		$error("Bridge busy right after reset");
	end

	start_between_frames: assert property (@(posedge clock) disable iff (reset)
		tx_start_i |-> !in_frame_q)
	else
	begin
		fail_count++;
		$error("UART start during a frame in progress");
	end

	// Popped channel must be granted, enabled and holding a sample
	pop_needs_grant: assert property (@(posedge clock) disable iff (reset)
		pop_i |-> grant_valid_i && stream_enable_i[grant_id_i] && !empty_i[grant_id_i])
	else
	begin
		fail_count++;
		$error("FIFO pop without a valid grant on an enabled channel holding a sample");
	end

endmodule

bind bt_stream_bridge bt_stream_bridge_asserts asserts0 (
	.clock(clock),
	.reset(reset),
	.txd_i(txd_o),
	.busy_i(busy_o),
	.pop_i(pop),
	.grant_valid_i(grant_valid),
	.grant_id_i(grant_id),
	.empty_i(empty),
	.stream_enable_i(stream_enable_i),
	.tx_start_i(tx_start),
	.tx_done_i(tx_done)
);

//--- sim/bt_stream_bridge_tb.sv
// Testbench with clock, reset, stimulus, UART decoder, expected packets, watchdog and summary
module bt_stream_bridge_tb;
	import bt_bridge_pkg::*;

	localparam packet_gap_t PACKET_GAP = 16'd64;
	localparam int BIT_PERIOD = 4;
	localparam int BYTE_GAP = 3;
	localparam int PACKET_CYCLES = PACKET_BYTES * (10 * BIT_PERIOD + BYTE_GAP) + PACKET_GAP;
	// 1 + 4 + 1 + 4 packets, plus idle checks and resets
	localparam int WATCHDOG_CYCLES = 10 * PACKET_CYCLES + 2000;
	// Falling edges of the stop bit left after its mid-bit sample
	localparam int STOP_TAIL = BIT_PERIOD - BIT_PERIOD / 2 - 1;

	logic clock;
	logic reset;
	sample_t [N_STREAMS-1:0] sample;
	logic [N_STREAMS-1:0] sample_valid;
	logic [N_STREAMS-1:0] stream_enable;
	logic send_enable;
	bit_period_t bit_period;
	gap_t byte_gap;
	logic txd;
	logic busy;

	byte_t expected_bytes[$];
	sample_t written [N_STREAMS];
	sample_t burst [6];
	string test_name = "reset";
	int byte_errors = 0;
	int protocol_errors = 0;
	int total_errors;

	bt_stream_bridge #(
		.FIFO_DEPTH(4),
		.PACKET_GAP(PACKET_GAP)
	) dut0 (
		.clock(clock),
		.reset(reset),
		.sample_i(sample),
		.sample_valid_i(sample_valid),
		.stream_enable_i(stream_enable),
		.send_enable_i(send_enable),
		.bit_period_i(bit_period),
		.byte_gap_i(byte_gap),
		.txd_o(txd),
		.busy_o(busy)
	);

	initial
	begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	function automatic sample_t random_sample();
		return sample_t'({$urandom(), $urandom(), $urandom(), $urandom()});
	endfunction

	// Channel byte, sample padded to 14 bytes MSB first, channel byte
	function automatic void expect_packet(input stream_id_t ch, input sample_t value);
		logic [(PACKET_BYTES-2)*8-1:0] body;
		body = {2'b00, value};
		expected_bytes.push_back(byte_t'(ch));
		for (int i = PACKET_BYTES - 3; i >= 0; i--)
			expected_bytes.push_back(body[i*8 +: 8]);
		expected_bytes.push_back(byte_t'(ch));
	endfunction

	task automatic apply_reset();
		@(negedge clock);
		reset = 1'b1;
		repeat (4) @(negedge clock);
		reset = 1'b0;
	endtask

	// One-cycle strobe on every channel in the mask
	task automatic write_samples(input logic [N_STREAMS-1:0] mask);
		@(negedge clock);
		for (int k = 0; k < N_STREAMS; k++)
		begin
			if (mask[k])
			begin
				written[k] = random_sample();
				sample[k] = written[k];
			end
		end
		sample_valid = mask;
		@(negedge clock);
		sample_valid = '0;
	endtask

	task automatic wait_packets_done();
		while (expected_bytes.size() != 0 || busy)
			@(negedge clock);
		repeat (4) @(negedge clock);
		assert (!busy)
		else
		begin
			protocol_errors++;
			$display("Extra packet started in test %s", test_name);
		end
	endtask

	// UART receiver, mid-bit samples on falling edges, gap check before each start bit
	initial
	begin
		byte_t rx;
		int idle;
		int rx_count;
		int gap;
		idle = 0;
		rx_count = 0;
		forever
		begin
			@(negedge clock);
			if (reset || txd)
				idle++;
			else
			begin
				gap = idle - STOP_TAIL;
				if (rx_count > 0)
				begin
					assert (gap >= ((rx_count % PACKET_BYTES == 0) ? int'(PACKET_GAP) : BYTE_GAP))
					else
					begin
						protocol_errors++;
						$display("Gap of %0d cycles before byte %0d is too short in test %s",
							gap, rx_count, test_name);
					end
				end
				repeat (BIT_PERIOD / 2) @(negedge clock);
				for (int b = 0; b < 8; b++)
				begin
					repeat (BIT_PERIOD) @(negedge clock);
					rx[b] = txd;
				end
				repeat (BIT_PERIOD) @(negedge clock);
				assert (txd)
				else
				begin
					protocol_errors++;
					$display("Stop bit missing after byte %0d in test %s", rx_count, test_name);
				end
				assert (expected_bytes.size() != 0)
				else
				begin
					protocol_errors++;
					$display("Unexpected byte %02h in test %s", rx, test_name);
				end
				if (expected_bytes.size() != 0)
				begin
					assert (rx == expected_bytes[0])
					else
					begin
						byte_errors++;
						$display("** Error %s: expected %02h, actual %02h",
							test_name, expected_bytes[0], rx);
					end
					void'(expected_bytes.pop_front());
				end
				rx_count++;
				idle = 0;
			end
		end
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("Timeout after %0d cycles, packets still outstanding", WATCHDOG_CYCLES);
		$display("*** FAILED ***");
		$finish;
	end

	initial
	begin
		void'($urandom(32'he9ef));
		reset = 1'b1;
		sample = '0;
		sample_valid = '0;
		stream_enable = '1;
		send_enable = 1'b1;
		bit_period = bit_period_t'(BIT_PERIOD);
		byte_gap = gap_t'(BYTE_GAP);
		repeat (4) @(negedge clock);
		reset = 1'b0;

		test_name = "idle_after_reset";
		repeat (50)
		begin
			@(negedge clock);
			assert (txd && !busy)
			else
			begin
				protocol_errors++;
				$display("Line not idle with no samples in test %s", test_name);
			end
		end

		test_name = "single_sample";
		write_samples(8'h08);
		expect_packet(3, written[3]);
		wait_packets_done();

		// Fresh reset so the search starts again at channel 0
		test_name = "round_robin";
		apply_reset();
		write_samples(8'h62);
		expect_packet(1, written[1]);
		expect_packet(5, written[5]);
		expect_packet(6, written[6]);
		while (!busy)
			@(negedge clock);
		write_samples(8'h01);
		expect_packet(0, written[0]);
		wait_packets_done();

		test_name = "channel_mask";
		stream_enable = 8'hfb;
		write_samples(8'h04);
		repeat (100)
		begin
			@(negedge clock);
			assert (!busy)
			else
			begin
				protocol_errors++;
				$display("Masked channel was sent in test %s", test_name);
			end
		end
		expect_packet(2, written[2]);
		stream_enable = '1;
		wait_packets_done();

		test_name = "fifo_overflow";
		send_enable = 1'b0;
		for (int n = 0; n < 6; n++)
		begin
			write_samples(8'h10);
			burst[n] = written[4];
		end
		for (int n = 0; n < 4; n++)
			expect_packet(4, burst[n]);
		@(negedge clock);
		send_enable = 1'b1;
		wait_packets_done();

		total_errors = byte_errors + protocol_errors + dut0.asserts0.fail_count;
		$display("Errors: %0d byte, %0d protocol, %0d assertion",
			byte_errors, protocol_errors, dut0.asserts0.fail_count);
		if (total_errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule
